/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = mazeGame_tb
FILELIST  = build.f
OBJDIR    = obj_dir

.PHONY: all lint clean

# build, run, and pass only when the testbench reports success
all:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "Verification passed"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* build.f */
+incdir+.
mazeGame_pkg.sv
pixelGenerator.sv
mazeTileMap.sv
playerSprite.sv
objectsMux.sv
mazeGameTop.sv
mazeGame_assertions.sv
mazeGame_tb.sv

/* mazeGameTop.sv */
// Top level of the maze game screen. Connects the raster generator,
// the maze and player drawing objects and the output mux.

`timescale 1ns/1ps
`default_nettype none

module mazeGameTop
(
	input  logic                 clk,
	input  logic                 resetN,
	input  logic                 moveStrobe,
	input  mazeGame_pkg::moveDir moveDir,
	output logic [10:0]          pixelX,
	output logic [10:0]          pixelY,
	output logic [7:0]           rgbOut,
	output logic [4:0]           playerCol,
	output logic [4:0]           playerRow
);

	logic       videoActive;
	logic       startOfFrame;
	logic       mazeDraw;
	logic [7:0] mazeRgb;
	logic       queryWall;
	logic [4:0] queryCol;
	logic [4:0] queryRow;
	logic       playerDraw;
	logic [7:0] playerRgb;

	pixelGenerator i_pixelGenerator (
		.clk(clk), .resetN(resetN), .pixelX(pixelX), .pixelY(pixelY),
		.videoActive(videoActive), .startOfFrame(startOfFrame));

	mazeTileMap i_mazeTileMap (
		.clk(clk), .resetN(resetN), .pixelX(pixelX), .pixelY(pixelY),
		.queryCol(queryCol), .queryRow(queryRow),
		.mazeDraw(mazeDraw), .mazeRgb(mazeRgb), .queryWall(queryWall));

	playerSprite i_playerSprite (
		.clk(clk), .resetN(resetN), .pixelX(pixelX), .pixelY(pixelY),
		.startOfFrame(startOfFrame), .moveStrobe(moveStrobe), .moveDir(moveDir),
		.queryWall(queryWall), .queryCol(queryCol), .queryRow(queryRow),
		.playerCol(playerCol), .playerRow(playerRow),
		.playerDraw(playerDraw), .playerRgb(playerRgb));

	objectsMux i_objectsMux (
		.clk(clk), .resetN(resetN), .videoActive(videoActive),
		.playerDraw(playerDraw), .playerRgb(playerRgb),
		.mazeDraw(mazeDraw), .mazeRgb(mazeRgb), .rgbOut(rgbOut));

endmodule

`default_nettype wire

/* mazeGame_assertions.sv */
// Concurrent checks bound into mazeGameTop: legal output colors, player never
// on a wall tile, and player moves only right after frame start, one tile at a time.

`timescale 1ns/1ps
`include "mazeGame_cfg.svh"
`default_nettype none

module mazeGame_assertions
(
	input logic       clk,
	input logic       resetN,
	input logic       startOfFrame,
	input logic [7:0] rgbOut,
	input logic [4:0] playerCol,
	input logic [4:0] playerRow
);

	logic [4:0] prevCol;
	logic [4:0] prevRow;
	logic       frameDly;    // startOfFrame one clock late
	logic       moved;
	int         stepSize;

	function automatic bit isWall(input int col, input int row);
		return (col == 0) || (row == 0) || (col == `MG_GRID_TILES - 1) ||
		       (row == `MG_GRID_TILES - 1) || ((col % 2 == 0) && (row % 2 == 0));
	endfunction

	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			prevCol  <= 5'(`MG_START_COL);
			prevRow  <= 5'(`MG_START_ROW);
			frameDly <= 1'b0;
		end
		else
		begin
			prevCol  <= playerCol;
			prevRow  <= playerRow;
			frameDly <= startOfFrame;
		end
	end

	always_comb
	begin
		moved    = (playerCol != prevCol) || (playerRow != prevRow);
		stepSize = ((playerCol > prevCol) ? int'(playerCol - prevCol) : int'(prevCol - playerCol)) +
		           ((playerRow > prevRow) ? int'(playerRow - prevRow) : int'(prevRow - playerRow));
	end

	colorLegal: assert property (@(posedge clk) disable iff (!resetN)
		rgbOut == `MG_WALL_COLOR || rgbOut == `MG_PLAYER_COLOR ||
		rgbOut == `MG_BACK_COLOR || rgbOut == 8'h00)
		else $error("rgbOut carries an unknown color %h", rgbOut);

	playerOffWall: assert property (@(posedge clk) disable iff (!resetN)
		!isWall(int'(playerCol), int'(playerRow)))
		else $error("player sits on a wall tile (%0d,%0d)", playerCol, playerRow);

	moveTiming: assert property (@(posedge clk) disable iff (!resetN) moved |-> frameDly)
		else $error("player moved outside frame start");

	moveStep: assert property (@(posedge clk) disable iff (!resetN) moved |-> stepSize == 1)
		else $error("player jumped %0d tiles", stepSize);

endmodule

bind mazeGameTop mazeGame_assertions i_mazeGameAssertions (
	.clk(clk), .resetN(resetN), .startOfFrame(startOfFrame), .rgbOut(rgbOut),
	.playerCol(playerCol), .playerRow(playerRow));

`default_nettype wire

/* mazeGame_cfg.svh */
// Raster, grid and color constants for the maze game screen.
// Include this in any module that needs the VGA timing, tile grid
// or the shared color codes.

`ifndef MAZEGAME_CFG_SVH
`define MAZEGAME_CFG_SVH

// raster timing, one pixel per clock
`define MG_H_ACTIVE     640
`define MG_V_ACTIVE     480
`define MG_H_TOTAL      800   // pixels per line incl. blanking
`define MG_V_TOTAL      525   // lines per frame incl. blanking

// tile grid, 16x16 tiles covering pixels 0..479 on both axes
`define MG_TILE_SHIFT   4
`define MG_GRID_TILES   30

// 8-bit RGB codes
`define MG_WALL_COLOR   8'h5B
`define MG_PLAYER_COLOR 8'hE0
`define MG_BACK_COLOR   8'h25   // background inside active video
`define MG_TRANSPARENT  8'hFF   // sent by an object that is not drawing

// player start tile
`define MG_START_COL    1
`define MG_START_ROW    1

`endif

/* mazeGame_pkg.sv */
// Shared types for the maze game: the tile kind held in the wall map
// and the direction carried with a move strobe.
// Referenced by scoped name from the modules that need them.

`default_nettype none

package mazeGame_pkg;

	// one bit per tile
	typedef enum logic
	{
		tileFree,
		tileWall
	} tileType;

	typedef enum logic [1:0]
	{
		dirUp,
		dirDown,
		dirLeft,
		dirRight
	} moveDir;

endpackage

`default_nettype wire

/* mazeGame_tb.sv */
// Directed testbench for the maze game screen. Walks the raster to chosen pixels,
// checks rgbOut against the maze rule and steps the player through free and
// blocked moves. Build and run with the Makefile, or compile with build.f.

`timescale 1ns/1ps
`include "mazeGame_cfg.svh"
`default_nettype none

module mazeGame_tb;

	localparam int WaitLimit  = `MG_H_TOTAL * `MG_V_TOTAL + 1000;   // one frame plus margin
	localparam int TileSize   = 1 << `MG_TILE_SHIFT;
	localparam int GridPixels = `MG_GRID_TILES * TileSize;

	logic                 clk;
	logic                 resetN;
	logic                 moveStrobe;
	mazeGame_pkg::moveDir moveDir;
	logic [10:0]          pixelX;
	logic [10:0]          pixelY;
	logic [7:0]           rgbOut;
	logic [4:0]           playerCol;
	logic [4:0]           playerRow;

	int errorCount;
	int checkCount;
	int expCol;      // reference player tile
	int expRow;

	mazeGameTop i_mazeGameTop (
		.clk(clk), .resetN(resetN), .moveStrobe(moveStrobe), .moveDir(moveDir),
		.pixelX(pixelX), .pixelY(pixelY), .rgbOut(rgbOut),
		.playerCol(playerCol), .playerRow(playerRow));

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// border tiles and even/even pillars are walls
	function automatic bit isWallTile(input int col, input int row);
		return (col == 0) || (row == 0) || (col == `MG_GRID_TILES - 1) ||
		       (row == `MG_GRID_TILES - 1) || ((col % 2 == 0) && (row % 2 == 0));
	endfunction

	task automatic checkValue(input string testName, input int expected, input int actual);
		checkCount++;
		if (expected !== actual)
		begin
			errorCount++;
			$display("** Error [%s] expected 0x%0h, actual 0x%0h at %0t",
			         testName, expected, actual, $time);
		end
	endtask

	task automatic waitPixel(input int x, input int y);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!(int'(pixelX) == x && int'(pixelY) == y) && cycles < WaitLimit)
		begin
			@(negedge clk);
			cycles++;
		end
		if (cycles >= WaitLimit)
		begin
			errorCount++;
			$display("timeout: raster never reached pixel (%0d,%0d)", x, y);
		end
	endtask

	task automatic waitFrameStart();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while ((pixelX != 11'd0 || pixelY != 11'd0) && cycles < WaitLimit)
		begin
			@(negedge clk);
			cycles++;
		end
		if (cycles >= WaitLimit)
		begin
			errorCount++;
			$display("timeout: no frame start seen");
		end
	endtask

	// rgbOut trails the counters by two clocks
	task automatic checkPixel(input string testName, input int x, input int y, input int expected);
		waitPixel(x, y);
		repeat (2) @(negedge clk);
		checkValue(testName, expected, int'(rgbOut));
	endtask

	task automatic resetState();
		repeat (16) @(posedge clk);
		resetN <= 1'b1;
		@(negedge clk);
		checkValue("reset rgbOut", 0, int'(rgbOut));
		checkValue("reset pixelX", 0, int'(pixelX));
		checkValue("reset pixelY", 0, int'(pixelY));
		checkValue("reset col", `MG_START_COL, int'(playerCol));
		checkValue("reset row", `MG_START_ROW, int'(playerRow));
	endtask

	task automatic mazeDrawing();
		int x;
		int y;
		int done;
		done = 0;
		while (done < 20)
		begin
			x = int'($urandom % GridPixels);
			y = int'($urandom % GridPixels);
			if ((x / TileSize) != expCol || (y / TileSize) != expRow)   // skip the player
			begin
				checkPixel("maze drawing", x, y, isWallTile(x / TileSize, y / TileSize) ?
				           int'(`MG_WALL_COLOR) : int'(`MG_BACK_COLOR));
				done++;
			end
		end
	endtask

	task automatic outsideGrid();
		checkPixel("beside grid", 500, 100, int'(`MG_BACK_COLOR));
		checkPixel("beside grid corner", 639, 479, int'(`MG_BACK_COLOR));
		checkPixel("h blanking", 700, 20, 0);
		checkPixel("v blanking", 100, 500, 0);
		checkPixel("last pixel", 799, 524, 0);
	endtask

	task automatic playerDrawing(input string testName);
		checkPixel(testName, expCol * TileSize, expRow * TileSize, int'(`MG_PLAYER_COLOR));
		checkPixel(testName, expCol * TileSize + 7, expRow * TileSize + 8, int'(`MG_PLAYER_COLOR));
		checkPixel(testName, expCol * TileSize + 15, expRow * TileSize + 15, int'(`MG_PLAYER_COLOR));
	endtask

	task automatic driveStrobe(input mazeGame_pkg::moveDir dir);
		@(posedge clk);
		moveStrobe <= 1'b1;
		moveDir    <= dir;
		@(posedge clk);
		moveStrobe <= 1'b0;
	endtask

	// reference model: step into the target tile unless it is a wall
	task automatic modelMove(input mazeGame_pkg::moveDir dir);
		int tCol;
		int tRow;
		tCol = expCol;
		tRow = expRow;
		case (dir)
			mazeGame_pkg::dirUp:    tRow--;
			mazeGame_pkg::dirDown:  tRow++;
			mazeGame_pkg::dirLeft:  tCol--;
			mazeGame_pkg::dirRight: tCol++;
		endcase
		if (!isWallTile(tCol, tRow))
		begin
			expCol = tCol;
			expRow = tRow;
		end
	endtask

	task automatic positionAfterFrame(input string testName);
		waitFrameStart();
		@(negedge clk);   // move lands on the clock after frame start
		checkValue({testName, " col"}, expCol, int'(playerCol));
		checkValue({testName, " row"}, expRow, int'(playerRow));
	endtask

	task automatic singleMove(input string testName, input mazeGame_pkg::moveDir dir);
		modelMove(dir);
		driveStrobe(dir);
		positionAfterFrame(testName);
	endtask

	task automatic doubleStrobe(input string testName, input mazeGame_pkg::moveDir first,
	                            input mazeGame_pkg::moveDir second);
		driveStrobe(first);
		driveStrobe(second);
		modelMove(second);   // only the later strobe counts
		positionAfterFrame(testName);
	endtask

	initial
	begin
		errorCount = 0;
		checkCount = 0;
		resetN     = 1'b0;
		moveStrobe = 1'b0;
		moveDir    = mazeGame_pkg::dirUp;
		expCol     = `MG_START_COL;
		expRow     = `MG_START_ROW;
		void'($urandom(32'h3be8_bdf3));

		resetState();
		mazeDrawing();
		outsideGrid();
		playerDrawing("player tile");
		singleMove("right to free tile", mazeGame_pkg::dirRight);   // (1,1) to (2,1)
		positionAfterFrame("no repeat without strobe");             // pending move is gone
		singleMove("down into pillar", mazeGame_pkg::dirDown);
		singleMove("left back", mazeGame_pkg::dirLeft);
		singleMove("down from column 1", mazeGame_pkg::dirDown);    // into row 2
		singleMove("left into border", mazeGame_pkg::dirLeft);
		singleMove("up to start", mazeGame_pkg::dirUp);
		singleMove("up into border", mazeGame_pkg::dirUp);
		doubleStrobe("second strobe wins", mazeGame_pkg::dirDown, mazeGame_pkg::dirRight);
		playerDrawing("player after moves");

		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* mazeTileMap.sv */
// Maze tile map drawing object. The 30 x 30 wall map follows a fixed rule:
// border tiles and tiles with even column and even row are walls.
// Drives a registered wall drawing request per pixel, plus a combinational
// tile query port used by the game logic to test a tile for a wall.

`timescale 1ns/1ps
`include "mazeGame_cfg.svh"
`default_nettype none

module mazeTileMap
(
	input  logic        clk,
	input  logic        resetN,
	input  logic [10:0] pixelX,
	input  logic [10:0] pixelY,
	input  logic [4:0]  queryCol,
	input  logic [4:0]  queryRow,
	output logic        mazeDraw,
	output logic [7:0]  mazeRgb,
	output logic        queryWall
);

	localparam int LastTile   = `MG_GRID_TILES - 1;
	localparam int GridPixels = `MG_GRID_TILES << `MG_TILE_SHIFT;   // 480

	mazeGame_pkg::tileType wallMap [0:LastTile][0:LastTile];       // [row][col]

	logic [4:0] tileCol;
	logic [4:0] tileRow;
	logic       insideGrid;
	logic       queryInRange;

	// map is fixed at elaboration
	for (genvar r = 0; r < `MG_GRID_TILES; r++)
	begin : genRow
		for (genvar c = 0; c < `MG_GRID_TILES; c++)
		begin : genCol
			localparam bit IsBorder = (r == 0) || (r == LastTile) || (c == 0) || (c == LastTile);
			localparam bit IsPillar = (r % 2 == 0) && (c % 2 == 0);

			assign wallMap[r][c] = (IsBorder || IsPillar) ? mazeGame_pkg::tileWall
			                                              : mazeGame_pkg::tileFree;
		end
	end

	// pixel to tile index, valid only inside the grid
	assign insideGrid = (pixelX < 11'(GridPixels)) && (pixelY < 11'(GridPixels));
	assign tileCol    = 5'(pixelX >> `MG_TILE_SHIFT);
	assign tileRow    = 5'(pixelY >> `MG_TILE_SHIFT);

	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			mazeDraw <= 1'b0;
			mazeRgb  <= `MG_TRANSPARENT;
		end
		else if (insideGrid)
		begin
			mazeDraw <= (wallMap[tileRow][tileCol] == mazeGame_pkg::tileWall);
			mazeRgb  <= `MG_WALL_COLOR;
		end
		else
		begin
			mazeDraw <= 1'b0;
			mazeRgb  <= `MG_TRANSPARENT;   // nothing to show outside the grid
		end
	end

	// second read port for game logic, off-grid tiles count as walls
	assign queryInRange = (queryCol <= 5'(LastTile)) && (queryRow <= 5'(LastTile));
	assign queryWall    = queryInRange ? (wallMap[queryRow][queryCol] == mazeGame_pkg::tileWall)
	                                   : 1'b1;

endmodule

`default_nettype wire

/* objectsMux.sv */
// Fixed-priority object mux for the single RGB output.
// Player beats maze, maze beats background; blanking is forced to black.
// Adds one register, so rgbOut trails the pixel counters by two cycles.

`timescale 1ns/1ps
`include "mazeGame_cfg.svh"
`default_nettype none

module objectsMux
(
	input  logic       clk,
	input  logic       resetN,
	input  logic       videoActive,
	input  logic       playerDraw,
	input  logic [7:0] playerRgb,
	input  logic       mazeDraw,
	input  logic [7:0] mazeRgb,
	output logic [7:0] rgbOut
);

	logic activeDly;   // videoActive lined up with the object outputs

	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			activeDly <= 1'b0;
			rgbOut    <= 8'h00;
		end
		else
		begin
			activeDly <= videoActive;

			if (playerDraw)
				rgbOut <= playerRgb;
			else if (mazeDraw)
				rgbOut <= mazeRgb;
			else if (activeDly)
				rgbOut <= `MG_BACK_COLOR;
			else
				rgbOut <= 8'h00;   // blanking
		end
	end

endmodule

`default_nettype wire

/* pixelGenerator.sv */
// VGA-style raster counter. Walks every pixel of an 800 x 525 frame,
// one per clock, and flags the 640 x 480 visible area and frame start.

`timescale 1ns/1ps
`include "mazeGame_cfg.svh"
`default_nettype none

module pixelGenerator
(
	input  logic        clk,
	input  logic        resetN,
	output logic [10:0] pixelX,
	output logic [10:0] pixelY,
	output logic        videoActive,
	output logic        startOfFrame
);

	logic [10:0] hCount;
	logic [10:0] vCount;
	logic        lineEnd;
	logic        frameEnd;

	assign lineEnd  = (hCount == 11'(`MG_H_TOTAL - 1));
	assign frameEnd = (vCount == 11'(`MG_V_TOTAL - 1));

	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			hCount <= '0;
			vCount <= '0;
		end
		else if (lineEnd)
		begin
			hCount <= '0;
			// vertical counter steps once per line
			if (frameEnd)
				vCount <= '0;
			else
				vCount <= vCount + 11'd1;
		end
		else
		begin
			hCount <= hCount + 11'd1;
		end
	end

	assign pixelX = hCount;
	assign pixelY = vCount;

	assign videoActive  = (hCount < 11'(`MG_H_ACTIVE)) && (vCount < 11'(`MG_V_ACTIVE));
	assign startOfFrame = (hCount == '0) && (vCount == '0); // one cycle at pixel (0,0)

endmodule

`default_nettype wire

/* playerSprite.sv */
// Player sprite drawing object. Keeps the player tile, latches the last
// move strobe as a pending move and applies it at frame start unless the
// maze reports a wall at the target tile. Draws the whole player tile.

`timescale 1ns/1ps
`include "mazeGame_cfg.svh"
`default_nettype none

module playerSprite
(
	input  logic                 clk,
	input  logic                 resetN,
	input  logic [10:0]          pixelX,
	input  logic [10:0]          pixelY,
	input  logic                 startOfFrame,
	input  logic                 moveStrobe,
	input  mazeGame_pkg::moveDir moveDir,
	input  logic                 queryWall,
	output logic [4:0]           queryCol,
	output logic [4:0]           queryRow,
	output logic [4:0]           playerCol,
	output logic [4:0]           playerRow,
	output logic                 playerDraw,
	output logic [7:0]           playerRgb
);

	logic                  pendingValid;
	mazeGame_pkg::moveDir  pendingDir;
	mazeGame_pkg::tileType targetType;
	logic                  onPlayerTile;

	// target tile of the pending move, sent to the maze as a query
	always_comb
	begin
		queryCol = playerCol;
		queryRow = playerRow;
		case (pendingDir)
			mazeGame_pkg::dirUp:    queryRow = playerRow - 5'd1;
			mazeGame_pkg::dirDown:  queryRow = playerRow + 5'd1;
			mazeGame_pkg::dirLeft:  queryCol = playerCol - 5'd1;
			mazeGame_pkg::dirRight: queryCol = playerCol + 5'd1;
			default: ;
		endcase
	end

	assign targetType = queryWall ? mazeGame_pkg::tileWall : mazeGame_pkg::tileFree;

	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			pendingValid <= 1'b0;
			pendingDir   <= mazeGame_pkg::dirUp;
			playerCol    <= 5'(`MG_START_COL);
			playerRow    <= 5'(`MG_START_ROW);
		end
		else
		begin
			if (startOfFrame && pendingValid && targetType == mazeGame_pkg::tileFree)
			begin
				playerCol <= queryCol;
				playerRow <= queryRow;
			end

			// a new strobe wins over the frame-start clear
			if (moveStrobe)
			begin
				pendingValid <= 1'b1;
				pendingDir   <= moveDir;
			end
			else if (startOfFrame)
				pendingValid <= 1'b0;   // applied or blocked, either way it is gone
		end
	end

	// full-width compare so pixels beyond the grid never alias onto a tile
	assign onPlayerTile = ((pixelX >> `MG_TILE_SHIFT) == 11'(playerCol)) &&
	                      ((pixelY >> `MG_TILE_SHIFT) == 11'(playerRow));

	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			playerDraw <= 1'b0;
			playerRgb  <= `MG_TRANSPARENT;
		end
		else
		begin
			playerDraw <= onPlayerTile;
			playerRgb  <= onPlayerTile ? `MG_PLAYER_COLOR : `MG_TRANSPARENT;
		end
	end

endmodule

`default_nettype wire
